//--- source/mips_pkg.sv
// ##################################################################
// mips package: word and register types, opcode and function
// encodings, ALU operations, controller states and fixed addresses.
// ##################################################################
`default_nettype none

package mips_pkg;

    // data and address word.
    typedef logic [31:0] word_t;

    // register number.
    typedef logic [4:0] reg_addr_t;

    // primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b00_0000,
        OP_J       = 6'b00_0010,
        OP_JAL     = 6'b00_0011,
        OP_BEQ     = 6'b00_0100,
        OP_BNE     = 6'b00_0101,
        OP_ADDIU   = 6'b00_1001,
        OP_SLTI    = 6'b00_1010,
        OP_ANDI    = 6'b00_1100,
        OP_ORI     = 6'b00_1101,
        OP_XORI    = 6'b00_1110,
        OP_LUI     = 6'b00_1111,
        OP_LW      = 6'b10_0011,
        OP_SW      = 6'b10_1011
    } opcode_t;

    // function field of special (r-type) instructions.
    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'b00_0000,
        FUNCT_SRL  = 6'b00_0010,
        FUNCT_JR   = 6'b00_1000,
        FUNCT_ADDU = 6'b10_0001,
        FUNCT_SUBU = 6'b10_0011,
        FUNCT_AND  = 6'b10_0100,
        FUNCT_OR   = 6'b10_0101,
        FUNCT_XOR  = 6'b10_0110,
        FUNCT_SLT  = 6'b10_1010,
        FUNCT_SLTU = 6'b10_1011
    } funct_t;

    // operations the decoder can ask of the ALU.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_t;

    // multicycle controller states.
    typedef enum logic [1:0] {
        STATE_FETCH,
        STATE_EXECUTE,
        STATE_MEMORY,
        STATE_WRITEBACK
    } cpu_state_t;

    // first fetch address after reset.
    localparam word_t RESET_VECTOR = 32'hBFC0_0000;

    // v0 is shown on the top level.
    localparam reg_addr_t REG_V0 = 5'd2;

    // ra is the link target of jal.
    localparam reg_addr_t REG_RA = 5'd31;

endpackage

`default_nettype wire

//--- source/regfile_if.sv
// ##################################################################
// register file interface: two read ports and one write port
// between the controller and the register file.
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

interface regfile_if;
    import mips_pkg::*;

    // read side.
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_val;
    word_t     rt_val;

    // write side takes effect on the clock edge.
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    modport controller (
        output rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        input  rs_val, rt_val
    );

    modport regfile (
        input  rs_addr, rt_addr, wr_en, wr_addr, wr_data,
        output rs_val, rt_val
    );

endinterface

`default_nettype wire

//--- source/reg_file.sv
// ##################################################################
// register file: 32 x 32-bit, two combinational reads, one write,
// register 0 hard wired to zero and v0 shown continuously.
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               reset,
    regfile_if.regfile         regs,
    output mips_pkg::word_t    register_v0
);
    import mips_pkg::*;

    word_t regs_q [32];

    // synchronous write that leaves register 0 alone.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (regs.wr_en && (regs.wr_addr != '0)) begin
            regs_q[regs.wr_addr] <= regs.wr_data;
        end
    end

    // reads see the stored value or zero for register 0.
    always_comb begin
        if (regs.rs_addr == '0) begin
            regs.rs_val = '0;
        end else begin
            regs.rs_val = regs_q[regs.rs_addr];
        end

        if (regs.rt_addr == '0) begin
            regs.rt_val = '0;
        end else begin
            regs.rt_val = regs_q[regs.rt_addr];
        end
    end

    assign register_v0 = regs_q[REG_V0];

endmodule

`default_nettype wire

//--- source/alu.sv
// ##################################################################
// ALU: add, subtract, logic, signed and unsigned compare, shifts
// and load-upper, all combinational.
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    input  mips_pkg::alu_op_t op,
    output mips_pkg::word_t   result
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            // compares give 1 or 0.
            ALU_SLT: begin
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            ALU_SLTU: begin
                result = (a < b) ? 32'd1 : 32'd0;
            end
            // shifts act on b as in the sll/srl encoding.
            ALU_SLL: begin
                result = b << shamt;
            end
            ALU_SRL: begin
                result = b >> shamt;
            end
            ALU_LUI: begin
                result = {b[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/mips_core_ctrl.sv
// ##################################################################
// multicycle controller: fetch, execute, memory and writeback
// states, decoder, pc with branch delay slot and Avalon master.
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module mips_core_ctrl (
    input  logic                clk,
    input  logic                reset,
    output logic                active,
    regfile_if.controller       regs,
    output mips_pkg::word_t     alu_a,
    output mips_pkg::word_t     alu_b,
    output logic [4:0]          alu_shamt,
    output mips_pkg::alu_op_t   alu_op,
    input  mips_pkg::word_t     alu_result,
    output mips_pkg::word_t     address,
    output logic                read,
    output logic                write,
    output mips_pkg::word_t     writedata,
    output logic [3:0]          byteenable,
    input  logic                waitrequest,
    input  mips_pkg::word_t     readdata
);
    import mips_pkg::*;

    cpu_state_t state;
    word_t      pc;
    word_t      ir;
    word_t      delay_target;
    logic       delay_pending;

    // decoded fields.
    word_t      instr;
    opcode_t    opcode;
    funct_t     funct;
    reg_addr_t  rd;
    word_t      imm_sext;
    word_t      imm_zext;

    // decoder outputs.
    logic       use_imm;
    logic       zero_ext;
    logic       writes_reg;
    logic       is_link;
    logic       is_load;
    logic       is_store;
    logic       take_jump;
    word_t      jump_target;
    reg_addr_t  dest;
    word_t      exec_next_pc;

    // in execute the new word is still on readdata.
    assign instr    = (state == STATE_EXECUTE) ? readdata : ir;
    assign opcode   = opcode_t'(instr[31:26]);
    assign funct    = funct_t'(instr[5:0]);
    assign rd       = instr[15:11];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};

    always_comb begin
        alu_op      = ALU_ADD;
        use_imm     = 1'b0;
        zero_ext    = 1'b0;
        writes_reg  = 1'b0;
        is_link     = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        take_jump   = 1'b0;
        jump_target = pc;
        dest        = rd;
        case (opcode)
            OP_SPECIAL: begin
                writes_reg = 1'b1;
                case (funct)
                    FUNCT_ADDU: alu_op = ALU_ADD;
                    FUNCT_SUBU: alu_op = ALU_SUB;
                    FUNCT_AND:  alu_op = ALU_AND;
                    FUNCT_OR:   alu_op = ALU_OR;
                    FUNCT_XOR:  alu_op = ALU_XOR;
                    FUNCT_SLT:  alu_op = ALU_SLT;
                    FUNCT_SLTU: alu_op = ALU_SLTU;
                    FUNCT_SLL:  alu_op = ALU_SLL;
                    FUNCT_SRL:  alu_op = ALU_SRL;
                    FUNCT_JR: begin
                        writes_reg  = 1'b0;
                        take_jump   = 1'b1;
                        jump_target = regs.rs_val;
                    end
                    default: writes_reg = 1'b0;
                endcase
            end
            // pc already points at the delay slot here.
            OP_J, OP_JAL: begin
                take_jump   = 1'b1;
                jump_target = {pc[31:28], instr[25:0], 2'b00};
                is_link     = (opcode == OP_JAL);
                writes_reg  = (opcode == OP_JAL);
                dest        = REG_RA;
            end
            OP_BEQ, OP_BNE: begin
                take_jump   = (regs.rs_val == regs.rt_val) ^ (opcode == OP_BNE);
                jump_target = pc + {imm_sext[29:0], 2'b00};
            end
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                use_imm    = 1'b1;
                writes_reg = 1'b1;
                dest       = instr[20:16];
                case (opcode)
                    OP_SLTI: alu_op = ALU_SLT;
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_XORI: alu_op = ALU_XOR;
                    OP_LUI:  alu_op = ALU_LUI;
                    default: alu_op = ALU_ADD;
                endcase
                zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                           (opcode == OP_XORI) || (opcode == OP_LUI);
            end
            // address is rs plus the sign-extended offset.
            OP_LW, OP_SW: begin
                use_imm  = 1'b1;
                dest     = instr[20:16];
                is_load  = (opcode == OP_LW);
                is_store = (opcode == OP_SW);
            end
            default: ;
        endcase
    end

    assign exec_next_pc = delay_pending ? delay_target : pc;

    // operands and register ports.
    assign regs.rs_addr = instr[25:21];
    assign regs.rt_addr = instr[20:16];
    assign alu_a        = regs.rs_val;
    assign alu_b        = !use_imm ? regs.rt_val : (zero_ext ? imm_zext : imm_sext);
    assign alu_shamt    = instr[10:6];

    assign regs.wr_en   = active && (((state == STATE_EXECUTE) && writes_reg) ||
                                     (state == STATE_WRITEBACK));
    assign regs.wr_addr = dest;
    assign regs.wr_data = (state == STATE_WRITEBACK) ? readdata :
                          (is_link ? pc + 32'd4 : alu_result);

    // Avalon master. outputs hold steady while waitrequest is high.
    assign address    = (state == STATE_MEMORY) ? alu_result : pc;
    assign read       = active && ((state == STATE_FETCH) ||
                                   ((state == STATE_MEMORY) && is_load));
    assign write      = active && (state == STATE_MEMORY) && is_store;
    assign writedata  = regs.rt_val;
    assign byteenable = 4'b1111;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= STATE_FETCH;
            pc            <= RESET_VECTOR;
            active        <= 1'b1;
            delay_pending <= 1'b0;
        end else if (active) begin
            case (state)
                STATE_FETCH: begin
                    if (!waitrequest) begin
                        pc    <= pc + 32'd4;
                        state <= STATE_EXECUTE;
                    end
                end
                STATE_EXECUTE: begin
                    ir <= readdata;
                    // the delay slot is done so the jump happens now.
                    if (delay_pending) begin
                        pc            <= delay_target;
                        delay_pending <= 1'b0;
                    end else if (take_jump) begin
                        delay_target  <= jump_target;
                        delay_pending <= 1'b1;
                    end
                    if (is_load || is_store) begin
                        state <= STATE_MEMORY;
                    end else begin
                        state  <= STATE_FETCH;
                        active <= (exec_next_pc != '0);
                    end
                end
                STATE_MEMORY: begin
                    if (!waitrequest) begin
                        if (is_load) begin
                            state <= STATE_WRITEBACK;
                        end else begin
                            state  <= STATE_FETCH;
                            active <= (pc != '0);
                        end
                    end
                end
                STATE_WRITEBACK: begin
                    state  <= STATE_FETCH;
                    active <= (pc != '0);
                end
                default: state <= STATE_FETCH;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/mips_cpu_bus.sv
// ##################################################################
// MIPS CPU top level: controller, register file and ALU behind an
// Avalon memory-mapped master port.
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus (
    input  logic              clk,
    input  logic              reset,
    output logic              active,
    output mips_pkg::word_t   register_v0,

    // Avalon master.
    output mips_pkg::word_t   address,
    output logic              write,
    output logic              read,
    input  logic              waitrequest,
    output mips_pkg::word_t   writedata,
    output logic [3:0]        byteenable,
    input  mips_pkg::word_t   readdata
);
    import mips_pkg::*;

    word_t   alu_a;
    word_t   alu_b;
    logic [4:0] alu_shamt;
    alu_op_t alu_op;
    word_t   alu_result;

    regfile_if regs_bus ();

    mips_core_ctrl ctrl0 (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .regs        (regs_bus.controller),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_shamt   (alu_shamt),
        .alu_op      (alu_op),
        .alu_result  (alu_result),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    reg_file reg_file0 (
        .clk         (clk),
        .reset       (reset),
        .regs        (regs_bus.regfile),
        .register_v0 (register_v0)
    );

    alu alu0 (
        .a      (alu_a),
        .b      (alu_b),
        .shamt  (alu_shamt),
        .op     (alu_op),
        .result (alu_result)
    );

endmodule

`default_nettype wire

//--- verification/avalon_mem_model.sv
// ##################################################################
// Avalon slave memory: program space at the reset vector, data
// space at 0x1000, random waitrequest stalls, one-cycle read latency.
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module avalon_mem_model (
    input  logic              clk,
    input  mips_pkg::word_t   address,
    input  logic              read,
    input  logic              write,
    input  mips_pkg::word_t   writedata,
    input  logic [3:0]        byteenable,
    output logic              waitrequest,
    output mips_pkg::word_t   readdata
);
    import mips_pkg::*;

    word_t  prog_mem [64];
    word_t  data_mem [64];
    integer seed;
    int     stall;
    int     wait_left;
    logic   request;
    logic   prog_hit;
    logic   data_hit;

    assign request  = read || write;
    assign prog_hit = (address[31:8] == RESET_VECTOR[31:8]);
    assign data_hit = (address[31:8] == 24'h00_0010);

    initial begin
        seed        = 44691;
        stall       = 0;
        wait_left   = 0;
        waitrequest = 1'b0;
        readdata    = '0;
    end

    // a request seen with waitrequest low was accepted, so a request
    // now is a new one and draws its own stall count.
    always @(negedge clk) begin
        if (!request) begin
            waitrequest <= 1'b0;
            wait_left   <= 0;
        end else if (!waitrequest) begin
            stall = $unsigned($random(seed)) % 4;
            wait_left   <= stall;
            waitrequest <= (stall != 0);
        end else begin
            wait_left   <= wait_left - 1;
            waitrequest <= (wait_left > 1);
        end
    end

    // accepted reads show up on readdata in the next cycle.
    always @(posedge clk) begin
        if (read && !waitrequest) begin
            if (prog_hit) begin
                readdata <= prog_mem[address[7:2]];
            end else if (data_hit) begin
                readdata <= data_mem[address[7:2]];
            end else begin
                readdata <= '0;
            end
        end
        // only whole-word writes are stored.
        if (write && !waitrequest && data_hit && (byteenable == 4'b1111)) begin
            data_mem[address[7:2]] <= writedata;
        end
    end

endmodule

`default_nettype wire

//--- verification/mips_cpu_bus_tb.sv
// ##################################################################
// testbench for the MIPS CPU: loads each program from the cases
// file, runs it to the halt and checks v0 and one data word.
// ##################################################################
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_tb;
    import mips_pkg::*;

    localparam int CASE_WORDS = 512;

    logic       clk;
    logic       reset;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       write;
    logic       read;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;

    word_t cases_mem [CASE_WORDS];
    int    case_index    = 0;
    int    cycle_count   = 0;
    int    timeout_limit = 0;
    int    error_count   = 0;
    int    fail_count    = 0;

    mips_cpu_bus dut0 (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    avalon_mem_model mem0 (
        .clk         (clk),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // twice 4 cycles per instruction and 3 stall cycles per transfer
    // plus reset and idle time for each case.
    function automatic int run_limit();
        int base;
        int n;
        int instrs;
        int transfers;
        int cases;
        base      = 0;
        instrs    = 0;
        transfers = 0;
        cases     = 0;
        while (base < CASE_WORDS && cases_mem[base] != '0) begin
            n = cases_mem[base];
            for (int i = 1; i <= n; i++) begin
                if (cases_mem[base + i][31:26] == OP_LW ||
                    cases_mem[base + i][31:26] == OP_SW) begin
                    transfers++;
                end
            end
            instrs    += n;
            transfers += n;
            cases++;
            base += n + 4;
        end
        return 2 * (4 * instrs + 3 * transfers) + 16 * cases;
    endfunction

    // clears both memory spaces and copies one program in.
    task automatic load_case(input int base);
        int n;
        n = cases_mem[base];
        for (int i = 0; i < 64; i++) begin
            mem0.prog_mem[i] = '0;
            mem0.data_mem[i] = '0;
        end
        for (int i = 0; i < n; i++) begin
            mem0.prog_mem[i] = cases_mem[base + 1 + i];
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("case %0d hung: active never fell within %0d cycles",
                     case_index, timeout_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int    base;
        int    n;
        int    case_errors;
        logic  woke;
        word_t data_addr;

        reset = 1'b1;
        for (int i = 0; i < CASE_WORDS; i++) begin
            cases_mem[i] = '0;
        end
        $readmemh("verification/program_cases.mem", cases_mem);
        timeout_limit = run_limit();

        base = 0;
        while (base < CASE_WORDS && cases_mem[base] != '0) begin
            n           = cases_mem[base];
            case_index  = case_index + 1;
            case_errors = 0;
            woke        = 1'b0;

            @(negedge clk);
            reset = 1'b1;
            load_case(base);
            repeat (4) @(negedge clk);
            reset = 1'b0;
            @(negedge clk);
            if (active !== 1'b1) begin
                $display("ERROR at %0t ns: case %0d active is %b after reset, expected 1",
                         $time, case_index, active);
                case_errors++;
            end

            // runs until the jump to address 0 and its delay slot are done.
            while (active !== 1'b0) begin
                @(negedge clk);
            end

            data_addr = cases_mem[base + n + 2];
            if (register_v0 !== cases_mem[base + n + 1]) begin
                $display("ERROR at %0t ns: case %0d register_v0 is %h, expected %h",
                         $time, case_index, register_v0, cases_mem[base + n + 1]);
                case_errors++;
            end
            if (mem0.data_mem[data_addr[7:2]] !== cases_mem[base + n + 3]) begin
                $display("ERROR at %0t ns: case %0d word at %h is %h, expected %h",
                         $time, case_index, data_addr, mem0.data_mem[data_addr[7:2]],
                         cases_mem[base + n + 3]);
                case_errors++;
            end

            // a halted CPU stays idle and off the bus.
            repeat (8) begin
                @(negedge clk);
                if (active !== 1'b0 || read !== 1'b0 || write !== 1'b0) begin
                    woke = 1'b1;
                end
            end
            if (woke) begin
                $display("case %0d: the CPU became active or used the bus after halting",
                         case_index);
                case_errors++;
            end

            error_count += case_errors;
            if (case_errors != 0) begin
                fail_count++;
            end
            $display("case %0d finished at %0t ns: %s", case_index, $time,
                     (case_errors == 0) ? "pass" : "fail");
            base = base + n + 4;
        end

        if (case_index == 0) begin
            $display("no test cases were found in the cases file");
            error_count++;
        end
        $display("cases run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 case_index, case_index - fail_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/program_cases.mem
// per case: instruction count, program words, then expected register_v0,
// data address and expected data word. a zero count ends the list.
// addu and subu with a negative operand.
00000006 24010064 2403FFF9 00232021 00641023 00000008 00000000
FFFFFF9C 00001000 00000000
// lui, ori, andi, xori, and, or, xor.
0000000A 3C01F0F0 34215A5A 2403FF00 00232024 3885FFFF 30638FF0
00A32025 00811026 00000008 00000000
0000F5A5 00001000 00000000
// slt, sltu, slti with negative operands, sll and srl.
0000000E 2401FFFB 24030003 0023202A 0061282B 2828FFFC 00042100 00084200
00014F02 00094B00 00851025 00481025 00491025 00000008 00000000
0000F111 00001000 00000000
// writes to register 0 are dropped.
00000005 24000055 24020077 00401021 00000008 00000000
00000077 00001000 00000000
// sw then lw through data memory, load result used next.
00000008 3C01CAFE 3421BEEF 24031000 AC610008 8C620008 24420001
00000008 00000000
CAFEBEF0 00001008 CAFEBEEF
// beq and bne, taken and not taken, with delay slots.
00000010 24010005 24030005 10230002 34420001 34420002 14230002 34420004
34420008 14200002 34420010 34420020 10200002 34420040 34420080
00000008 00000000
000000DD 00001000 00000000
// jal, jr through ra and j, link word stored to memory.
0000000D 24051000 0FF00007 24020001 34420004 0BF0000B 34420008 34420100
ACBF0000 03E00008 34420002 34420200 00000008 34420010
0000001F 00001000 BFC0000C
00000000

//--- verilog.f
source/mips_pkg.sv
source/regfile_if.sv
source/reg_file.sv
source/alu.sv
source/mips_core_ctrl.sv
source/mips_cpu_bus.sv
verification/avalon_mem_model.sv
verification/mips_cpu_bus_tb.sv
